//--- Makefile
# Verilator build of the execute slice testbench

SRCS := $(filter-out +%,$(shell cat compile.f))

.PHONY: all run clean

all: obj_dir/Vpipe_core_tb

# rebuilt only when a source or the file list changes
obj_dir/Vpipe_core_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module pipe_core_tb \
		-f compile.f -o Vpipe_core_tb

# exit status of the simulator is the test result
run: obj_dir/Vpipe_core_tb
	./obj_dir/Vpipe_core_tb

clean:
	rm -rf obj_dir

//--- compile.f
cpu_pkg.sv
reg_file.sv
id_stage.sv
id_reg.sv
ex_stage.sv
wb_stage.sv
pipe_core_top.sv
pipe_core_asserts.sv
pipe_core_tb.sv

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;
    localparam int shamt_w    = 5;   // shift amount from low bits of operand b

    // ----------------------------------------------------------
    // instruction fields
    // ----------------------------------------------------------
    localparam int op_msb  = 31;
    localparam int op_lsb  = 26;
    localparam int rd_msb  = 25;
    localparam int rd_lsb  = 21;
    localparam int ra_msb  = 20;
    localparam int ra_lsb  = 16;
    localparam int rb_msb  = 15;
    localparam int rb_lsb  = 11;
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;

    // opcodes, anything not listed is a nop
    typedef enum logic [5:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SHL  = 6'h06,
        OP_SHR  = 6'h07,   // logical
        OP_SRA  = 6'h08,
        OP_ADDI = 6'h10,
        OP_ANDI = 6'h11,
        OP_ORI  = 6'h12,
        OP_LUI  = 6'h13,
        OP_BEQ  = 6'h20,
        OP_BNE  = 6'h21,
        OP_BLT  = 6'h22,   // signed
        OP_JMP  = 6'h23
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SHL, ALU_SHR, ALU_SRA, ALU_PASSB
    } alu_op_t;

    typedef enum logic [2:0] {
        CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_ALWAYS
    } cmp_op_t;

endpackage

`default_nettype wire

//--- ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  logic                       id_en,
    input  cpu_pkg::alu_op_t           id_alu_op,
    input  logic [cpu_pkg::word_w-1:0] id_alu_in_0,
    input  logic [cpu_pkg::word_w-1:0] id_alu_in_1,
    input  cpu_pkg::cmp_op_t           id_cmp_op,
    input  logic [cpu_pkg::word_w-1:0] id_cmp_in_0,
    input  logic [cpu_pkg::word_w-1:0] id_cmp_in_1,
    output logic [cpu_pkg::word_w-1:0] alu_out,
    output logic                       cond_true,
    output logic                       ex_taken
);

    logic [cpu_pkg::shamt_w-1:0] shamt;

    assign shamt = id_alu_in_1[cpu_pkg::shamt_w-1:0];

    // ----------------------------------------------------------
    // alu
    // ----------------------------------------------------------
    always_comb begin
        case (id_alu_op)
            cpu_pkg::ALU_ADD:   alu_out = id_alu_in_0 + id_alu_in_1;
            cpu_pkg::ALU_SUB:   alu_out = id_alu_in_0 - id_alu_in_1;
            cpu_pkg::ALU_AND:   alu_out = id_alu_in_0 & id_alu_in_1;
            cpu_pkg::ALU_OR:    alu_out = id_alu_in_0 | id_alu_in_1;
            cpu_pkg::ALU_XOR:   alu_out = id_alu_in_0 ^ id_alu_in_1;
            cpu_pkg::ALU_SHL:   alu_out = id_alu_in_0 << shamt;
            cpu_pkg::ALU_SHR:   alu_out = id_alu_in_0 >> shamt;
            cpu_pkg::ALU_SRA:   alu_out = $signed(id_alu_in_0) >>> shamt;
            cpu_pkg::ALU_PASSB: alu_out = id_alu_in_1;   // lui
            default:            alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------
    // branch compare
    // ----------------------------------------------------------
    always_comb begin
        case (id_cmp_op)
            cpu_pkg::CMP_EQ:     cond_true = (id_cmp_in_0 == id_cmp_in_1);
            cpu_pkg::CMP_NE:     cond_true = (id_cmp_in_0 != id_cmp_in_1);
            cpu_pkg::CMP_LT:     cond_true = ($signed(id_cmp_in_0) < $signed(id_cmp_in_1));
            cpu_pkg::CMP_ALWAYS: cond_true = 1'b1;
            default:             cond_true = 1'b0;
        endcase
    end

    // only a live instruction redirects
    assign ex_taken = id_en & cond_true;

endmodule

`default_nettype wire

//--- id_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_reg (
    input  logic                           clk,
    input  logic                           rst_n,
    // decoded instruction
    input  cpu_pkg::alu_op_t               alu_op,
    input  logic [cpu_pkg::word_w-1:0]     alu_in_0,
    input  logic [cpu_pkg::word_w-1:0]     alu_in_1,
    input  cpu_pkg::cmp_op_t               cmp_op,
    input  logic [cpu_pkg::word_w-1:0]     cmp_in_0,
    input  logic [cpu_pkg::word_w-1:0]     cmp_in_1,
    input  logic [cpu_pkg::reg_addr_w-1:0] dst_addr,
    input  logic                           gpr_we,
    input  logic [cpu_pkg::word_w-1:0]     br_target,
    input  logic                           instr_valid,
    // pipeline control
    input  logic                           stall,
    input  logic                           flush,
    // to ex
    output logic                           id_en,
    output cpu_pkg::alu_op_t               id_alu_op,
    output logic [cpu_pkg::word_w-1:0]     id_alu_in_0,
    output logic [cpu_pkg::word_w-1:0]     id_alu_in_1,
    output cpu_pkg::cmp_op_t               id_cmp_op,
    output logic [cpu_pkg::word_w-1:0]     id_cmp_in_0,
    output logic [cpu_pkg::word_w-1:0]     id_cmp_in_1,
    output logic [cpu_pkg::reg_addr_w-1:0] id_dst_addr,
    output logic                           id_gpr_we,
    output logic [cpu_pkg::word_w-1:0]     id_br_target
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_en        <= 1'b0;
            id_alu_op    <= cpu_pkg::ALU_NOP;
            id_alu_in_0  <= '0;
            id_alu_in_1  <= '0;
            id_cmp_op    <= cpu_pkg::CMP_NOP;
            id_cmp_in_0  <= '0;
            id_cmp_in_1  <= '0;
            id_dst_addr  <= '0;
            id_gpr_we    <= 1'b0;
            id_br_target <= '0;
        end else if (!stall) begin         // stall holds everything
            if (flush) begin               // squash to a nop
                id_en        <= 1'b0;
                id_alu_op    <= cpu_pkg::ALU_NOP;
                id_alu_in_0  <= '0;
                id_alu_in_1  <= '0;
                id_cmp_op    <= cpu_pkg::CMP_NOP;
                id_cmp_in_0  <= '0;
                id_cmp_in_1  <= '0;
                id_dst_addr  <= '0;
                id_gpr_we    <= 1'b0;
                id_br_target <= '0;
            end else begin
                id_en        <= instr_valid;
                id_alu_op    <= alu_op;
                id_alu_in_0  <= alu_in_0;
                id_alu_in_1  <= alu_in_1;
                id_cmp_op    <= cmp_op;
                id_cmp_in_0  <= cmp_in_0;
                id_cmp_in_1  <= cmp_in_1;
                id_dst_addr  <= dst_addr;
                id_gpr_we    <= gpr_we & instr_valid;  // empty slot forwards nothing
                id_br_target <= br_target;
            end
        end
    end

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic [cpu_pkg::word_w-1:0]     instr,
    input  logic [cpu_pkg::word_w-1:0]     pc,
    output logic [cpu_pkg::reg_addr_w-1:0] ra_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rb_addr,
    input  logic [cpu_pkg::word_w-1:0]     ra_data,
    input  logic [cpu_pkg::word_w-1:0]     rb_data,
    input  logic                           ex_fwd_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_fwd_addr,
    input  logic [cpu_pkg::word_w-1:0]     ex_fwd_data,
    input  logic                           wb_en,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [cpu_pkg::word_w-1:0]     wb_data,
    output cpu_pkg::alu_op_t               alu_op,
    output logic [cpu_pkg::word_w-1:0]     alu_in_0,
    output logic [cpu_pkg::word_w-1:0]     alu_in_1,
    output cpu_pkg::cmp_op_t               cmp_op,
    output logic [cpu_pkg::word_w-1:0]     cmp_in_0,
    output logic [cpu_pkg::word_w-1:0]     cmp_in_1,
    output logic [cpu_pkg::reg_addr_w-1:0] dst_addr,
    output logic                           gpr_we,
    output logic [cpu_pkg::word_w-1:0]     br_target
);

    cpu_pkg::opcode_t               opcode;
    logic [cpu_pkg::reg_addr_w-1:0] rd_field;
    logic [cpu_pkg::imm_w-1:0]      imm16;
    logic [cpu_pkg::word_w-1:0]     imm_sext;
    logic [cpu_pkg::word_w-1:0]     imm_zext;
    logic [cpu_pkg::word_w-1:0]     ra_val;
    logic [cpu_pkg::word_w-1:0]     rb_val;

    // ex result wins over wb result
    function automatic logic [cpu_pkg::word_w-1:0] fwd(
        input logic [cpu_pkg::reg_addr_w-1:0] addr,
        input logic [cpu_pkg::word_w-1:0]     rf_val,
        input logic                           e_we,
        input logic [cpu_pkg::reg_addr_w-1:0] e_addr,
        input logic [cpu_pkg::word_w-1:0]     e_data,
        input logic                           w_we,
        input logic [cpu_pkg::reg_addr_w-1:0] w_addr,
        input logic [cpu_pkg::word_w-1:0]     w_data
    );
        logic [cpu_pkg::word_w-1:0] val;
        if (addr == '0)                   val = '0;
        else if (e_we && e_addr == addr)  val = e_data;
        else if (w_we && w_addr == addr)  val = w_data;
        else                              val = rf_val;
        return val;
    endfunction

    // ----------------------------------------------------------
    // fields
    // ----------------------------------------------------------
    assign opcode   = cpu_pkg::opcode_t'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
    assign rd_field = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    assign imm16    = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];
    assign imm_sext = {{(cpu_pkg::word_w-cpu_pkg::imm_w){imm16[cpu_pkg::imm_w-1]}}, imm16};
    assign imm_zext = {{(cpu_pkg::word_w-cpu_pkg::imm_w){1'b0}}, imm16};
    assign ra_addr  = instr[cpu_pkg::ra_msb:cpu_pkg::ra_lsb];
    assign dst_addr = rd_field;

    // branches compare ra against rd through port b
    always_comb begin
        case (opcode)
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BLT: rb_addr = rd_field;
            default: rb_addr = instr[cpu_pkg::rb_msb:cpu_pkg::rb_lsb];
        endcase
    end

    always_comb begin
        ra_val = fwd(ra_addr, ra_data, ex_fwd_we, ex_fwd_addr, ex_fwd_data,
                     wb_en, wb_addr, wb_data);
        rb_val = fwd(rb_addr, rb_data, ex_fwd_we, ex_fwd_addr, ex_fwd_data,
                     wb_en, wb_addr, wb_data);
    end

    assign br_target = pc + {imm_sext[cpu_pkg::word_w-3:0], 2'b00};  // pc + 4*imm

    // ----------------------------------------------------------
    // decode
    // ----------------------------------------------------------
    always_comb begin
        alu_op   = cpu_pkg::ALU_NOP;
        alu_in_0 = ra_val;
        alu_in_1 = rb_val;
        cmp_op   = cpu_pkg::CMP_NOP;
        cmp_in_0 = ra_val;
        cmp_in_1 = rb_val;
        gpr_we   = 1'b1;
        case (opcode)
            cpu_pkg::OP_ADD:  alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SUB:  alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND:  alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:   alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR:  alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_SHL:  alu_op = cpu_pkg::ALU_SHL;
            cpu_pkg::OP_SHR:  alu_op = cpu_pkg::ALU_SHR;
            cpu_pkg::OP_SRA:  alu_op = cpu_pkg::ALU_SRA;
            cpu_pkg::OP_ADDI: begin
                alu_op   = cpu_pkg::ALU_ADD;
                alu_in_1 = imm_sext;
            end
            cpu_pkg::OP_ANDI: begin
                alu_op   = cpu_pkg::ALU_AND;
                alu_in_1 = imm_zext;
            end
            cpu_pkg::OP_ORI: begin
                alu_op   = cpu_pkg::ALU_OR;
                alu_in_1 = imm_zext;
            end
            cpu_pkg::OP_LUI: begin
                alu_op   = cpu_pkg::ALU_PASSB;
                alu_in_1 = {imm16, {(cpu_pkg::word_w-cpu_pkg::imm_w){1'b0}}};
            end
            cpu_pkg::OP_BEQ: begin
                cmp_op = cpu_pkg::CMP_EQ;
                gpr_we = 1'b0;
            end
            cpu_pkg::OP_BNE: begin
                cmp_op = cpu_pkg::CMP_NE;
                gpr_we = 1'b0;
            end
            cpu_pkg::OP_BLT: begin
                cmp_op = cpu_pkg::CMP_LT;
                gpr_we = 1'b0;
            end
            cpu_pkg::OP_JMP: begin
                cmp_op = cpu_pkg::CMP_ALWAYS;  // jump is an always-true branch
                gpr_we = 1'b0;
            end
            default: gpr_we = 1'b0;            // nop
        endcase
        if (rd_field == '0) begin
            gpr_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- pipe_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_core_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           instr_valid,
    input logic                           stall,
    input logic                           flush,
    input logic                           id_en,
    input cpu_pkg::alu_op_t               id_alu_op,
    input logic [cpu_pkg::word_w-1:0]     id_alu_in_0,
    input logic [cpu_pkg::word_w-1:0]     id_alu_in_1,
    input cpu_pkg::cmp_op_t               id_cmp_op,
    input logic [cpu_pkg::word_w-1:0]     id_cmp_in_0,
    input logic [cpu_pkg::word_w-1:0]     id_cmp_in_1,
    input logic [cpu_pkg::reg_addr_w-1:0] id_dst_addr,
    input logic                           id_gpr_we,
    input logic [cpu_pkg::word_w-1:0]     id_br_target
);

    logic seen_valid;  // any valid input since reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_valid <= 1'b0;
        end else if (instr_valid) begin
            seen_valid <= 1'b1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (!seen_valid && !instr_valid) |=> !id_en)
        else $error("id_en set before any valid instruction");

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !stall) |=> !id_en)
        else $error("flush did not clear id_en");

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(id_en) && $stable(id_alu_op) && $stable(id_alu_in_0)
                   && $stable(id_alu_in_1) && $stable(id_cmp_op) && $stable(id_cmp_in_0)
                   && $stable(id_cmp_in_1) && $stable(id_dst_addr) && $stable(id_gpr_we)
                   && $stable(id_br_target)))
        else $error("id/ex register changed during stall");

endmodule

bind id_reg pipe_core_asserts u_asserts (
    .clk, .rst_n, .instr_valid, .stall, .flush, .id_en, .id_alu_op, .id_alu_in_0,
    .id_alu_in_1, .id_cmp_op, .id_cmp_in_0, .id_cmp_in_1, .id_dst_addr, .id_gpr_we,
    .id_br_target
);

`default_nettype wire

//--- pipe_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_core_tb;

    localparam int table_len  = 35;
    localparam int rand_iters = 12;
    localparam int rand_count = rand_iters * 5;  // lui/ori pairs plus one op
    localparam int max_rows   = table_len + rand_count;

    logic        clk, rst_n, instr_valid, stall;
    logic [31:0] instr, pc;
    logic        wb_en, branch_taken;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data, branch_target;

    // stimulus and expected result two cycles later
    logic [31:0] t_instr [max_rows];
    logic [31:0] t_pc    [max_rows];
    logic        t_valid [max_rows];
    logic        t_stall [max_rows];
    logic        e_en    [max_rows];
    logic [4:0]  e_addr  [max_rows];
    logic [31:0] e_data  [max_rows];
    logic        e_br    [max_rows];
    logic [31:0] e_tgt   [max_rows];
    int          n_rows;

    logic [31:0] model [32];  // register model for the random section
    logic [31:0] rng;

    pipe_core_top uut (
        .clk, .rst_n, .instr_valid, .instr, .pc, .stall,
        .wb_en, .wb_addr, .wb_data, .branch_taken, .branch_target
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] enc_r(cpu_pkg::opcode_t op, logic [4:0] rd,
                                          logic [4:0] ra, logic [4:0] rb);
        return {op, rd, ra, rb, 11'b0};
    endfunction

    function automatic logic [31:0] enc_i(cpu_pkg::opcode_t op, logic [4:0] rd,
                                          logic [4:0] ra, logic [15:0] imm);
        return {op, rd, ra, imm};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_pkg::opcode_t pick_op(logic [2:0] k);
        case (k)
            3'd0:    return cpu_pkg::OP_ADD;
            3'd1:    return cpu_pkg::OP_SUB;
            3'd2:    return cpu_pkg::OP_AND;
            3'd3:    return cpu_pkg::OP_OR;
            3'd4:    return cpu_pkg::OP_XOR;
            3'd5:    return cpu_pkg::OP_SHL;
            3'd6:    return cpu_pkg::OP_SHR;
            default: return cpu_pkg::OP_SRA;
        endcase
    endfunction

    // expected result of a register op from the instruction set rules
    function automatic logic [31:0] apply_op(cpu_pkg::opcode_t op, logic [31:0] a,
                                             logic [31:0] b);
        case (op)
            cpu_pkg::OP_ADD: return a + b;
            cpu_pkg::OP_SUB: return a - b;
            cpu_pkg::OP_AND: return a & b;
            cpu_pkg::OP_OR:  return a | b;
            cpu_pkg::OP_XOR: return a ^ b;
            cpu_pkg::OP_SHL: return a << b[4:0];
            cpu_pkg::OP_SHR: return a >> b[4:0];
            default:         return 32'($signed(a) >>> b[4:0]);
        endcase
    endfunction

    task automatic add_row(logic [31:0] ins, logic [31:0] p, logic v, logic s,
                           logic en, logic [4:0] addr, logic [31:0] data,
                           logic br, logic [31:0] tgt);
        t_instr[n_rows] = ins;
        t_pc[n_rows]    = p;
        t_valid[n_rows] = v;
        t_stall[n_rows] = s;
        e_en[n_rows]    = en;
        e_addr[n_rows]  = addr;
        e_data[n_rows]  = data;
        e_br[n_rows]    = br;
        e_tgt[n_rows]   = tgt;
        n_rows++;
    endtask

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t: %s got %h expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_row(int j);
        check($sformatf("row %0d wb_en", j), 32'(wb_en), 32'(e_en[j]));
        if (e_en[j]) begin
            check($sformatf("row %0d wb_addr", j), 32'(wb_addr), 32'(e_addr[j]));
            check($sformatf("row %0d wb_data", j), wb_data, e_data[j]);
        end
        check($sformatf("row %0d branch_taken", j), 32'(branch_taken), 32'(e_br[j]));
        if (e_br[j]) begin
            check($sformatf("row %0d branch_target", j), branch_target, e_tgt[j]);
        end
    endtask

    // ------------------------------------------------------------
    // directed table
    // ------------------------------------------------------------
    task automatic build_table();
        add_row(enc_i(cpu_pkg::OP_ADDI, 1, 0, 16'd5),    32'h00, 1, 0, 1, 1, 32'd5, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 2, 0, 16'hfffd), 32'h04, 1, 0, 1, 2, 32'hfffffffd, 0, 0);
        add_row(enc_r(cpu_pkg::OP_ADD, 3, 1, 2),  32'h08, 1, 0, 1, 3, 32'd2, 0, 0);  // fwd both
        add_row(enc_r(cpu_pkg::OP_SUB, 4, 3, 1),  32'h0c, 1, 0, 1, 4, 32'hfffffffd, 0, 0);
        add_row(enc_r(cpu_pkg::OP_AND, 5, 2, 1),  32'h10, 1, 0, 1, 5, 32'd5, 0, 0);
        add_row(enc_r(cpu_pkg::OP_OR,  6, 1, 3),  32'h14, 1, 0, 1, 6, 32'd7, 0, 0);
        add_row(enc_r(cpu_pkg::OP_XOR, 7, 6, 1),  32'h18, 1, 0, 1, 7, 32'd2, 0, 0);
        add_row(enc_r(cpu_pkg::OP_SHL, 8, 1, 3),  32'h1c, 1, 0, 1, 8, 32'h14, 0, 0);
        add_row(enc_r(cpu_pkg::OP_SHR, 9, 2, 3),  32'h20, 1, 0, 1, 9, 32'h3fffffff, 0, 0);
        add_row(enc_r(cpu_pkg::OP_SRA, 10, 2, 3), 32'h24, 1, 0, 1, 10, 32'hffffffff, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ANDI, 11, 2, 16'h8f0f), 32'h28, 1, 0, 1, 11, 32'h8f0d, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ORI, 12, 1, 16'h8000),  32'h2c, 1, 0, 1, 12, 32'h8005, 0, 0);
        add_row(enc_i(cpu_pkg::OP_LUI, 13, 0, 16'h1234),  32'h30, 1, 0, 1, 13, 32'h12340000, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 0, 1, 16'd7), 32'h34, 1, 0, 0, 0, 0, 0, 0);  // r0
        add_row(32'h0, 32'h38, 1, 0, 0, 0, 0, 0, 0);                                  // nop
        add_row(enc_r(cpu_pkg::OP_ADD, 14, 13, 12), 32'h3c, 1, 0, 1, 14, 32'h12348005, 0, 0);
        // a taken branch squashes the one slot behind it
        add_row(enc_i(cpu_pkg::OP_BEQ, 5, 1, 16'd4),    32'h40, 1, 0, 0, 0, 0, 1, 32'h50);
        add_row(enc_i(cpu_pkg::OP_ADDI, 15, 0, 16'd1),  32'h44, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 15, 0, 16'd9),  32'h50, 1, 0, 1, 15, 32'd9, 0, 0);
        add_row(enc_i(cpu_pkg::OP_BNE, 5, 1, 16'd8),    32'h54, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_BLT, 1, 2, 16'hfffe), 32'h58, 1, 0, 0, 0, 0, 1, 32'h50);
        add_row(enc_i(cpu_pkg::OP_ADDI, 16, 0, 16'd1),  32'h5c, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_BLT, 2, 1, 16'd3),    32'h50, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_BEQ, 2, 1, 16'd3),    32'h54, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_BNE, 2, 1, 16'd4),    32'h58, 1, 0, 0, 0, 0, 1, 32'h68);
        add_row(enc_i(cpu_pkg::OP_ADDI, 16, 0, 16'd1),  32'h5c, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_JMP, 0, 0, 16'h10),   32'h68, 1, 0, 0, 0, 0, 1, 32'ha8);
        add_row(enc_r(cpu_pkg::OP_ADD, 17, 1, 1),       32'h6c, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_r(cpu_pkg::OP_ADD, 17, 15, 1),      32'ha8, 1, 0, 1, 17, 32'he, 0, 0);
        // empty fetch slots neither retire nor forward nor redirect
        add_row(enc_i(cpu_pkg::OP_JMP, 0, 0, 16'h20),   32'hac, 0, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 15, 0, 16'h33), 32'hac, 0, 0, 0, 0, 0, 0, 0);
        add_row(enc_r(cpu_pkg::OP_ADD, 16, 15, 1),      32'hac, 1, 0, 1, 16, 32'he, 0, 0);
        // held addi retires once after a one-cycle stall
        add_row(enc_i(cpu_pkg::OP_ADDI, 18, 0, 16'h77), 32'hb0, 1, 0, 0, 0, 0, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 20, 0, 16'h55), 32'hb4, 1, 1, 1, 18, 32'h77, 0, 0);
        add_row(enc_i(cpu_pkg::OP_ADDI, 19, 18, 16'd1), 32'hb4, 1, 0, 1, 19, 32'h78, 0, 0);
    endtask

    // lui/ori loads of random operands followed by a dependent op
    task automatic build_random();
        logic [31:0]      a, b, p;
        logic [4:0]       rd;
        cpu_pkg::opcode_t op;
        p = 32'h100;
        for (int k = 0; k < rand_iters; k++) begin
            rng = xorshift(rng);
            a = rng;
            rng = xorshift(rng);
            b = rng;
            rng = xorshift(rng);
            op = pick_op(rng[2:0]);
            rd = 5'(22 + (rng[15:8] % 10));
            model[20] = a;
            model[21] = b;
            model[rd] = apply_op(op, model[20], model[21]);
            add_row(enc_i(cpu_pkg::OP_LUI, 20, 0, a[31:16]), p, 1, 0, 1, 20,
                    {a[31:16], 16'h0}, 0, 0);
            add_row(enc_i(cpu_pkg::OP_ORI, 20, 20, a[15:0]), p + 4, 1, 0, 1, 20, a, 0, 0);
            add_row(enc_i(cpu_pkg::OP_LUI, 21, 0, b[31:16]), p + 8, 1, 0, 1, 21,
                    {b[31:16], 16'h0}, 0, 0);
            add_row(enc_i(cpu_pkg::OP_ORI, 21, 21, b[15:0]), p + 12, 1, 0, 1, 21, b, 0, 0);
            add_row(enc_r(op, rd, 20, 21), p + 16, 1, 0, 1, rd, model[rd], 0, 0);
            p = p + 20;
        end
    endtask

    // ------------------------------------------------------------
    // run
    // ------------------------------------------------------------
    initial begin
        #((table_len + rand_count + 20) * 100);
        $display("Test failures found");
        $fatal(1, "watchdog timeout, the run did not finish in time");
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        stall       = 1'b0;
        n_rows      = 0;
        rng         = 32'hd54d0734;
        build_table();
        build_random();
        repeat (8) @(posedge clk);
        #10 rst_n = 1'b1;
        for (int i = 0; i < n_rows + 2; i++) begin
            @(posedge clk);
            #10;
            if (i >= 2) begin
                check_row(i - 2);   // result lands two edges after presentation
            end
            if (i < n_rows) begin
                instr       = t_instr[i];
                pc          = t_pc[i];
                instr_valid = t_valid[i];
                stall       = t_stall[i];
            end else begin
                instr_valid = 1'b0;
                instr       = '0;
                stall       = 1'b0;
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- pipe_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_core_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::word_w-1:0]     instr,
    input  logic [cpu_pkg::word_w-1:0]     pc,
    input  logic                           stall,
    output logic                           wb_en,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::word_w-1:0]     wb_data,
    output logic                           branch_taken,
    output logic [cpu_pkg::word_w-1:0]     branch_target
);

    // regfile ports
    logic [cpu_pkg::reg_addr_w-1:0] ra_addr, rb_addr;
    logic [cpu_pkg::word_w-1:0]     ra_data, rb_data;

    // decoded bundle
    cpu_pkg::alu_op_t               alu_op;
    cpu_pkg::cmp_op_t               cmp_op;
    logic [cpu_pkg::word_w-1:0]     alu_in_0, alu_in_1, cmp_in_0, cmp_in_1, br_target;
    logic [cpu_pkg::reg_addr_w-1:0] dst_addr;
    logic                           gpr_we;

    // id/ex outputs
    logic                           id_en, id_gpr_we;
    cpu_pkg::alu_op_t               id_alu_op;
    cpu_pkg::cmp_op_t               id_cmp_op;
    logic [cpu_pkg::word_w-1:0]     id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1;
    logic [cpu_pkg::word_w-1:0]     id_br_target;
    logic [cpu_pkg::reg_addr_w-1:0] id_dst_addr;

    // execute results
    logic [cpu_pkg::word_w-1:0]     alu_out;
    logic                           ex_taken;

    reg_file u_reg_file (
        .clk, .rst_n, .ra_addr, .rb_addr, .ra_data, .rb_data,
        .we(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
    );

    id_stage u_id_stage (
        .instr, .pc, .ra_addr, .rb_addr, .ra_data, .rb_data,
        .ex_fwd_we(id_gpr_we), .ex_fwd_addr(id_dst_addr), .ex_fwd_data(alu_out),
        .wb_en, .wb_addr, .wb_data,
        .alu_op, .alu_in_0, .alu_in_1, .cmp_op, .cmp_in_0, .cmp_in_1,
        .dst_addr, .gpr_we, .br_target
    );

    id_reg u_id_reg (
        .clk, .rst_n, .alu_op, .alu_in_0, .alu_in_1, .cmp_op, .cmp_in_0, .cmp_in_1,
        .dst_addr, .gpr_we, .br_target, .instr_valid, .stall, .flush(ex_taken),
        .id_en, .id_alu_op, .id_alu_in_0, .id_alu_in_1, .id_cmp_op,
        .id_cmp_in_0, .id_cmp_in_1, .id_dst_addr, .id_gpr_we, .id_br_target
    );

    // cond_true is folded into ex_taken inside the stage
    ex_stage u_ex_stage (
        .id_en, .id_alu_op, .id_alu_in_0, .id_alu_in_1, .id_cmp_op,
        .id_cmp_in_0, .id_cmp_in_1, .alu_out, .cond_true(), .ex_taken
    );

    wb_stage u_wb_stage (
        .clk, .rst_n, .stall, .id_en, .id_gpr_we, .id_dst_addr, .id_br_target,
        .alu_out, .ex_taken, .wb_en, .wb_addr, .wb_data, .branch_taken, .branch_target
    );

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rb_addr,
    output logic [cpu_pkg::word_w-1:0]     ra_data,
    output logic [cpu_pkg::word_w-1:0]     rb_data,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [cpu_pkg::word_w-1:0]     wr_data
);

    logic [cpu_pkg::word_w-1:0] regs [2**cpu_pkg::reg_addr_w];

    // write port, r0 stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // async reads
    assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
    assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

//--- wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           stall,
    input  logic                           id_en,
    input  logic                           id_gpr_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_dst_addr,
    input  logic [cpu_pkg::word_w-1:0]     id_br_target,
    input  logic [cpu_pkg::word_w-1:0]     alu_out,
    input  logic                           ex_taken,
    output logic                           wb_en,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
    output logic [cpu_pkg::word_w-1:0]     wb_data,
    output logic                           branch_taken,
    output logic [cpu_pkg::word_w-1:0]     branch_target
);

    // enables, bubble while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en        <= 1'b0;
            branch_taken <= 1'b0;
        end else if (stall) begin
            wb_en        <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            wb_en        <= id_en & id_gpr_we;
            branch_taken <= ex_taken;        // one-cycle pulse
        end
    end

    // payload, qualified by the enables above
    always_ff @(posedge clk) begin
        wb_addr       <= id_dst_addr;
        wb_data       <= alu_out;
        branch_target <= id_br_target;
    end

endmodule

`default_nettype wire
